// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_mbus
FLIST     := flist.f

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := obj_dir/V$(TOP)
LOG  := sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== flist.f ====
mbus_pkg.sv
map_pkg.sv
master_port.sv
mbus_arbiter.sv
work_ram.sv
zbus_bridge.sv
mbus_top.sv
tb_clock.sv
mbus_assert.sv
tb_mbus.sv

// ==== map_pkg.sv ====
// ------------------
// Console address map
// Region bounds, register addresses and the open bus value
// ------------------

package map_pkg;

	// ROM region 000000-9FFFFF, word address bound
	localparam logic [23:1] ROM_TOP_WORD = 23'h50_0000;

	// Z80 window, A00000-A0FFFF with the upper half mirrored
	localparam logic [7:0] ZBUS_BASE_HI = 8'hA0;

	// 8 KB of Z80 RAM seen as word positions
	localparam int ZRAM_WORDS = 4096;

	// ------------------
	// Control registers
	// ------------------
	// A11100 bus request, A11200 Z80 reset release
	localparam logic [23:1] CTRL_BUSREQ_WORD = 23'h50_8880;
	localparam logic [23:1] CTRL_RESET_WORD  = 23'h50_8900;
	localparam int          CTRL_BIT         = 8;

	// Work RAM E00000-FFFFFF, 64 KB mirrored
	localparam logic [2:0] RAM_TOP3  = 3'b111;
	localparam int         RAM_WORDS = 32768;

	// Read value of anything unmapped
	localparam logic [15:0] OPEN_BUS = 16'hFFFF;

endpackage

// ==== master_port.sv ====
// ------------------
// Master port
// Four-phase req/ack endpoint, holds one request for the arbiter
// ------------------

module master_port (
	input  logic                MCLK,
	input  logic                reset,
	input  logic                host_req,
	input  mbus_pkg::mbus_req_t host_cmd,
	output logic                host_ack,
	output mbus_pkg::mbus_rsp_t host_rsp,
	output logic                pend,
	output mbus_pkg::mbus_req_t cmd,
	input  logic                grant,
	input  logic                done,
	input  mbus_pkg::mbus_rsp_t rsp
);
	import mbus_pkg::*;

	typedef enum logic [1:0] {
		P_IDLE,
		P_PENDING,
		P_SERVING,
		P_ACKED
	} pstate_t;

	pstate_t   state;
	mbus_req_t cmd_q;
	mbus_rsp_t rsp_q;

	assign pend     = (state == P_PENDING);
	assign host_ack = (state == P_ACKED);
	assign cmd      = cmd_q;
	assign host_rsp = rsp_q;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			state <= P_IDLE;
		end else begin
			case (state)
			P_IDLE:
				if (host_req) begin
					cmd_q <= host_cmd;
					state <= P_PENDING;
				end
			P_PENDING:
				if (grant)
					state <= P_SERVING;
			P_SERVING:
				if (done) begin
					rsp_q <= rsp;
					state <= P_ACKED;
				end
			// Ack stays up until the master lets go of req
			P_ACKED:
				if (!host_req)
					state <= P_IDLE;
			default:
				state <= P_IDLE;
			endcase
		end
	end

endmodule

// ==== mbus_arbiter.sv ====
// ------------------
// Main bus arbiter
// Fixed priority between masters, address decode, ROM toggle
// handshake and the Z80 control registers
// ------------------

module mbus_arbiter (
	input  logic                              MCLK,
	input  logic                              reset,
	input  logic [mbus_pkg::NUM_MASTERS-1:0]  pend,
	input  mbus_pkg::mbus_req_t               cmd [mbus_pkg::NUM_MASTERS],
	output logic [mbus_pkg::NUM_MASTERS-1:0]  grant,
	output logic [mbus_pkg::NUM_MASTERS-1:0]  done,
	output mbus_pkg::mbus_rsp_t               rsp,
	input  logic [23:0]                       rom_words,
	output logic [22:0]                       rom_addr,
	output logic                              rom_req,
	input  logic                              rom_ack,
	input  mbus_pkg::mbus_word_t              rom_data,
	output logic                              ram_we,
	output logic [1:0]                        ram_be,
	output logic [14:0]                       ram_addr,
	output mbus_pkg::mbus_word_t              ram_d,
	input  mbus_pkg::mbus_word_t              ram_q,
	output logic                              zstart,
	output mbus_pkg::mbus_req_t               zcmd,
	input  logic                              zdone,
	input  logic [7:0]                        zq,
	output logic                              z80_busreq,
	output logic                              z80_run
);
	import mbus_pkg::*;
	import map_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SELECT,
		ST_RAM,
		ST_ZBUS,
		ST_ROM,
		ST_FINISH
	} state_t;

	state_t     state;
	midx_t      owner;
	midx_t      pick;
	logic       any_pend;
	mbus_req_t  cur;
	mbus_word_t data;
	mbus_word_t ctrl_q;
	logic       sel_rom;
	logic       sel_zbus;
	logic       sel_ctrl;
	logic       sel_ram;
	logic       rom_hit;

	// Lowest pending index wins
	always_comb begin
		pick     = '0;
		any_pend = 1'b0;
		for (int i = NUM_MASTERS - 1; i >= 0; i--) begin
			if (pend[i]) begin
				pick     = midx_t'(i);
				any_pend = 1'b1;
			end
		end
	end

	// ------------------
	// Region decode
	// ------------------
	assign sel_rom  = (cur.addr < ROM_TOP_WORD);
	assign sel_zbus = (cur.addr[23:16] == ZBUS_BASE_HI);
	assign sel_ctrl = (cur.addr == CTRL_BUSREQ_WORD) || (cur.addr == CTRL_RESET_WORD);
	assign sel_ram  = (cur.addr[23:21] == RAM_TOP3);
	// Only reads inside the cartridge size go out to the ROM
	assign rom_hit  = sel_rom && !cur.we && ({1'b0, cur.addr} < rom_words);

	// Bus request flag reads 0 once the Z80 has released the bus
	always_comb begin
		ctrl_q = OPEN_BUS;
		if (cur.addr == CTRL_BUSREQ_WORD)
			ctrl_q[CTRL_BIT] = ~(z80_busreq & z80_run);
	end

	always_comb begin
		grant = '0;
		done  = '0;
		if (state == ST_SELECT)
			grant[owner] = 1'b1;
		if (state == ST_FINISH)
			done[owner] = 1'b1;
	end

	assign rsp.rdata = data;
	assign rom_addr  = cur.addr;
	assign ram_addr  = cur.addr[15:1];
	assign ram_d     = cur.wdata;
	assign ram_be    = cur.be;
	assign ram_we    = (state == ST_SELECT) && sel_ram && cur.we;
	assign zstart    = (state == ST_SELECT) && sel_zbus;
	assign zcmd      = cur;

	// ------------------
	// Bus FSM
	// ------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state      <= ST_IDLE;
			owner      <= '0;
			rom_req    <= 1'b0;
			z80_busreq <= 1'b0;
			z80_run    <= 1'b0;
		end else begin
			case (state)
			ST_IDLE:
				if (any_pend) begin
					owner <= pick;
					cur   <= cmd[pick];
					state <= ST_SELECT;
				end
			ST_SELECT: begin
				// Writes and misses finish with open bus
				data  <= OPEN_BUS;
				state <= ST_FINISH;
				if (sel_ram) begin
					state <= ST_RAM;
				end else if (sel_zbus) begin
					state <= ST_ZBUS;
				end else if (rom_hit) begin
					rom_req <= ~rom_ack;
					state   <= ST_ROM;
				end else if (sel_ctrl) begin
					if (cur.we && cur.be[1]) begin
						if (cur.addr == CTRL_BUSREQ_WORD)
							z80_busreq <= cur.wdata[CTRL_BIT];
						else
							z80_run <= cur.wdata[CTRL_BIT];
					end else if (!cur.we) begin
						data <= ctrl_q;
					end
				end
			end
			ST_RAM: begin
				if (!cur.we)
					data <= ram_q;
				state <= ST_FINISH;
			end
			ST_ZBUS:
				if (zdone) begin
					if (!cur.we)
						data <= {zq, zq};
					state <= ST_FINISH;
				end
			ST_ROM:
				if (rom_req == rom_ack) begin
					data  <= rom_data;
					state <= ST_FINISH;
				end
			ST_FINISH:
				state <= ST_IDLE;
			default:
				state <= ST_IDLE;
			endcase
		end
	end

endmodule

// ==== mbus_assert.sv ====
// ------------------
// Bus assertions
// Master handshake rules and the ROM toggle protocol
// ------------------

module mbus_assert (
	input logic                             MCLK,
	input logic                             reset,
	input logic [mbus_pkg::NUM_MASTERS-1:0] host_req,
	input logic [mbus_pkg::NUM_MASTERS-1:0] host_ack,
	input logic                             rom_req,
	input logic                             rom_ack
);
	import mbus_pkg::*;

	for (genvar i = 0; i < NUM_MASTERS; i++) begin : g_hs
		// Ack only answers a live request
		a_ack_needs_req: assert property (@(posedge MCLK) disable iff (reset)
			$rose(host_ack[i]) |-> host_req[i])
			else $error("ack rose without req on master %0d", i);

		a_ack_holds: assert property (@(posedge MCLK) disable iff (reset)
			(host_ack[i] && host_req[i]) |=> host_ack[i])
			else $error("ack dropped while req still high on master %0d", i);
	end

	// A new ROM read starts only once the last one has closed
	a_rom_toggle: assert property (@(posedge MCLK) disable iff (reset)
		(rom_req != $past(rom_req)) |-> ($past(rom_req) == $past(rom_ack)))
		else $error("rom_req toggled while a ROM read was open");

endmodule

bind mbus_top mbus_assert i_mbus_assert (.*);

// ==== mbus_pkg.sv ====
// ------------------
// Main bus types
// Request and response words passed between the master ports,
// the arbiter and the slaves
// ------------------

package mbus_pkg;

	// Master 0 has the highest priority
	localparam int NUM_MASTERS = 3;
	localparam int MIDX_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

	typedef logic [MIDX_W-1:0] midx_t;

	typedef logic [15:0] mbus_word_t;

	// ------------------
	// Request, 42 bits
	// ------------------
	// be[1] is the upper lane (even byte), be[0] the lower lane (odd byte)
	typedef struct packed {
		logic [23:1] addr;
		mbus_word_t  wdata;
		logic        we;
		logic [1:0]  be;
	} mbus_req_t;

	// ------------------
	// Response, 16 bits
	// ------------------
	typedef struct packed {
		mbus_word_t rdata;
	} mbus_rsp_t;

endpackage

// ==== mbus_top.sv ====
// ------------------
// Main bus top level
// Master ports, arbiter, work RAM and Z80 window
// ------------------

module mbus_top (
	input  logic                              MCLK,
	input  logic                              reset,
	input  logic [mbus_pkg::NUM_MASTERS-1:0]  host_req,
	input  mbus_pkg::mbus_req_t               host_cmd [mbus_pkg::NUM_MASTERS],
	output logic [mbus_pkg::NUM_MASTERS-1:0]  host_ack,
	output mbus_pkg::mbus_rsp_t               host_rsp [mbus_pkg::NUM_MASTERS],
	input  logic [23:0]                       rom_words,
	output logic [22:0]                       rom_addr,
	output logic                              rom_req,
	input  logic                              rom_ack,
	input  mbus_pkg::mbus_word_t              rom_data,
	output logic                              z80_busreq,
	output logic                              z80_run
);
	import mbus_pkg::*;

	logic [NUM_MASTERS-1:0] pend;
	logic [NUM_MASTERS-1:0] grant;
	logic [NUM_MASTERS-1:0] done;
	mbus_req_t              cmd [NUM_MASTERS];
	mbus_rsp_t              rsp;
	logic                   ram_we;
	logic [1:0]             ram_be;
	logic [14:0]            ram_addr;
	mbus_word_t             ram_d;
	mbus_word_t             ram_q;
	logic                   zstart;
	mbus_req_t              zcmd;
	logic                   zdone;
	logic [7:0]             zq;

	// ------------------
	// Master side
	// ------------------
	for (genvar i = 0; i < NUM_MASTERS; i++) begin : g_port
		master_port i_port (
			.MCLK     (MCLK),
			.reset    (reset),
			.host_req (host_req[i]),
			.host_cmd (host_cmd[i]),
			.host_ack (host_ack[i]),
			.host_rsp (host_rsp[i]),
			.pend     (pend[i]),
			.cmd      (cmd[i]),
			.grant    (grant[i]),
			.done     (done[i]),
			.rsp      (rsp)
		);
	end

	mbus_arbiter i_arbiter (
		.MCLK       (MCLK),
		.reset      (reset),
		.pend       (pend),
		.cmd        (cmd),
		.grant      (grant),
		.done       (done),
		.rsp        (rsp),
		.rom_words  (rom_words),
		.rom_addr   (rom_addr),
		.rom_req    (rom_req),
		.rom_ack    (rom_ack),
		.rom_data   (rom_data),
		.ram_we     (ram_we),
		.ram_be     (ram_be),
		.ram_addr   (ram_addr),
		.ram_d      (ram_d),
		.ram_q      (ram_q),
		.zstart     (zstart),
		.zcmd       (zcmd),
		.zdone      (zdone),
		.zq         (zq),
		.z80_busreq (z80_busreq),
		.z80_run    (z80_run)
	);

	// ------------------
	// Slaves
	// ------------------
	work_ram i_work_ram (
		.MCLK (MCLK),
		.we   (ram_we),
		.be   (ram_be),
		.addr (ram_addr),
		.d    (ram_d),
		.q    (ram_q)
	);

	zbus_bridge i_zbus (
		.MCLK   (MCLK),
		.reset  (reset),
		.start  (zstart),
		.zcmd   (zcmd),
		.busreq (z80_busreq),
		.run    (z80_run),
		.zdone  (zdone),
		.zq     (zq)
	);

endmodule

// ==== tb_clock.sv ====
// ------------------
// Testbench clock
// Free-running clock and an initial reset pulse
// ------------------

module tb_clock #(
	parameter int PERIOD       = 8,
	parameter int RESET_CYCLES = 4
) (
	output logic MCLK,
	output logic reset
);

	initial begin
		MCLK  = 1'b0;
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge MCLK);
		reset <= 1'b0;
	end

	always #(PERIOD / 2) MCLK = ~MCLK;

endmodule

// ==== tb_mbus.sv ====
// ------------------
// Main bus testbench
// Three masters, a ROM model and a shadow reference of the map
// ------------------

module tb_mbus;
	import mbus_pkg::*;

	localparam int TIMEOUT_CYCLES = 20000;
	localparam int RAND_SEED      = 32'h90cd_5fed;
	localparam int ROM_READS      = 24;
	localparam int MIX_XFERS      = 32;

	logic                   MCLK;
	logic                   reset;
	logic [NUM_MASTERS-1:0] host_req;
	mbus_req_t              host_cmd [NUM_MASTERS];
	logic [NUM_MASTERS-1:0] host_ack;
	mbus_rsp_t              host_rsp [NUM_MASTERS];
	logic [23:0]            rom_words;
	logic [22:0]            rom_addr;
	logic                   rom_req;
	logic                   rom_ack;
	mbus_word_t             rom_data;
	logic                   z80_busreq;
	logic                   z80_run;

	// Shadow state of the reference
	mbus_word_t             sh_ram [int];
	logic [7:0]             sh_z [int];
	logic                   sh_busreq;
	logic                   sh_run;
	string                  test_name [NUM_MASTERS];
	logic [NUM_MASTERS-1:0] ack_prev;
	mbus_rsp_t              exp_rsp;
	int                     cycles;
	logic                   rom_busy;
	int                     rom_wait;

	tb_clock #(.PERIOD(8), .RESET_CYCLES(4)) i_clock (.MCLK(MCLK), .reset(reset));

	mbus_top i_mbus_top (.*);

	// ------------------
	// Checks
	// ------------------
	task automatic check_rsp(input string name, input mbus_rsp_t exp, input mbus_rsp_t act);
		if (act !== exp) begin
			$display("** Error %s expected %h actual %h", name, exp, act);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_ctrl(input string name, input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp) begin
			$display("** Error %s control expected %b actual %b", name, exp, act);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	endtask

	// Expected read data, shadow updated for writes
	function automatic mbus_rsp_t ref_access(input mbus_req_t c);
		mbus_rsp_t  r;
		mbus_word_t w;
		logic [15:0] off;
		int         zi;
		int         wi;
		logic       free;
		r.rdata = 16'hFFFF;
		off     = {c.addr[15:1], ~c.be[1]};
		free    = sh_busreq && sh_run;
		if (c.addr[23:21] == 3'b111) begin
			wi = int'(c.addr[15:1]);
			w  = sh_ram.exists(wi) ? sh_ram[wi] : 16'h0000;
			if (c.we) begin
				if (c.be[1])
					w[15:8] = c.wdata[15:8];
				if (c.be[0])
					w[7:0] = c.wdata[7:0];
				sh_ram[wi] = w;
			end else begin
				r.rdata = w;
			end
		end else if (c.addr[23:16] == 8'hA0) begin
			// 8 KB mirrored once, upper 16 KB of the window is empty
			zi = int'(off[12:0]);
			if (free && off[14] == 1'b0) begin
				if (c.we)
					sh_z[zi] = c.be[1] ? c.wdata[15:8] : c.wdata[7:0];
				else
					r.rdata = {sh_z[zi], sh_z[zi]};
			end
		end else if ({c.addr, 1'b0} < 24'hA0_0000) begin
			if (!c.we && {1'b0, c.addr} < rom_words)
				r.rdata = c.addr[16:1] ^ 16'hA5C3;
		end else if ({c.addr, 1'b0} == 24'hA1_1100 || {c.addr, 1'b0} == 24'hA1_1200) begin
			if (c.we && c.be[1]) begin
				if ({c.addr, 1'b0} == 24'hA1_1100)
					sh_busreq = c.wdata[8];
				else
					sh_run = c.wdata[8];
			end else if (!c.we && {c.addr, 1'b0} == 24'hA1_1100) begin
				r.rdata[8] = ~(sh_busreq & sh_run);
			end
		end
		return r;
	endfunction

	function automatic mbus_req_t make_req(input logic [23:0] ba, input logic we,
		input logic [1:0] be, input mbus_word_t wdata);
		mbus_req_t c;
		c.addr  = ba[23:1];
		c.we    = we;
		c.be    = be;
		c.wdata = wdata;
		return c;
	endfunction

	// One full four-phase cycle on master m
	task automatic transfer(input int m, input mbus_req_t c, input string name);
		@(posedge MCLK);
		test_name[m] = name;
		host_cmd[m] <= c;
		host_req[m] <= 1'b1;
		do @(negedge MCLK); while (!host_ack[m]);
		@(posedge MCLK);
		host_req[m] <= 1'b0;
		do @(negedge MCLK); while (host_ack[m]);
	endtask

	task automatic ram_traffic(input int m, input logic [23:0] base, input int n, input string name);
		logic [23:0] ba;
		for (int i = 0; i < 16; i++)
			transfer(m, make_req(base + 24'(2 * i), 1'b1, 2'b11, mbus_word_t'($urandom)), name);
		for (int i = 0; i < n; i++) begin
			ba = base + 24'(2 * ($urandom % 16));
			transfer(m, make_req(ba, 1'b1, 2'(1 + $urandom % 3), mbus_word_t'($urandom)), name);
			transfer(m, make_req(ba, 1'b0, 2'b11, 16'h0), name);
		end
	endtask

	// Z80 byte access, even bytes ride the upper lane
	// The unused lane carries the inverted byte
	task automatic zbyte(input logic [23:0] ba, input logic we, input logic [7:0] b,
		input string name);
		transfer(0, make_req(ba, we, ba[0] ? 2'b01 : 2'b10, ba[0] ? {~b, b} : {b, ~b}), name);
	endtask

	// ------------------
	// Compare process
	// ------------------
	always @(negedge MCLK) begin
		if (!reset) begin
			for (int m = 0; m < NUM_MASTERS; m++) begin
				if (host_ack[m] && !ack_prev[m]) begin
					exp_rsp = ref_access(host_cmd[m]);
					check_rsp(test_name[m], exp_rsp, host_rsp[m]);
					check_ctrl(test_name[m], {sh_busreq, sh_run}, {z80_busreq, z80_run});
				end
			end
		end
		ack_prev = host_ack;
	end

	// ROM model, answers each toggle after a random wait
	always @(posedge MCLK) begin
		if (reset) begin
			rom_busy <= 1'b0;
		end else if (!rom_busy && rom_req != rom_ack) begin
			rom_busy <= 1'b1;
			rom_wait <= int'($urandom % 8);
		end else if (rom_busy) begin
			if (rom_wait == 0) begin
				rom_data <= rom_addr[15:0] ^ 16'hA5C3;
				rom_ack  <= rom_req;
				rom_busy <= 1'b0;
			end else begin
				rom_wait <= rom_wait - 1;
			end
		end
	end

	always @(posedge MCLK) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, a request never completed", cycles);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	end

	initial begin
		logic [23:0] zb;
		void'($urandom(RAND_SEED));
		host_req  = '0;
		rom_ack   = 1'b0;
		rom_data  = 16'h0000;
		rom_words = 24'h10_0000;
		cycles    = 0;
		sh_busreq = 1'b0;
		sh_run    = 1'b0;
		ack_prev  = '0;
		for (int m = 0; m < NUM_MASTERS; m++)
			host_cmd[m] = '0;
		do @(negedge MCLK); while (reset);

		ram_traffic(0, 24'hE0_8000, 24, "ram_byte_lanes");

		for (int i = 0; i < ROM_READS; i++) begin
			transfer(0, make_req({23'($urandom % 32'h10_0000), 1'b0}, 1'b0, 2'b11, 16'h0),
				"rom_read");
			transfer(0, make_req({23'(32'h10_0000 + $urandom % 32'h40_0000), 1'b0}, 1'b0,
				2'b11, 16'h0), "rom_beyond_size");
		end
		transfer(0, make_req(24'h00_0100, 1'b1, 2'b11, 16'h1234), "rom_write");

		zbyte(24'hA0_0010, 1'b1, 8'h5A, "zbus_not_free");
		zbyte(24'hA0_0010, 1'b0, 8'h00, "zbus_not_free");
		transfer(0, make_req(24'hA1_1100, 1'b1, 2'b11, 16'h0100), "ctrl_busreq");
		transfer(0, make_req(24'hA1_1100, 1'b0, 2'b11, 16'h0), "ctrl_read");
		zbyte(24'hA0_0011, 1'b0, 8'h00, "zbus_not_free");
		transfer(0, make_req(24'hA1_1200, 1'b1, 2'b11, 16'h0100), "ctrl_run");
		transfer(0, make_req(24'hA1_1100, 1'b0, 2'b11, 16'h0), "ctrl_read");
		transfer(0, make_req(24'hA1_1200, 1'b0, 2'b11, 16'h0), "ctrl_read");

		// Known byte, then a write while the Z80 holds the bus must not land
		zbyte(24'hA0_0010, 1'b1, 8'hC3, "zbus_write");
		transfer(0, make_req(24'hA1_1200, 1'b1, 2'b11, 16'h0000), "ctrl_run");
		zbyte(24'hA0_0010, 1'b1, 8'h5A, "zbus_not_free");
		zbyte(24'hA0_0010, 1'b0, 8'h00, "zbus_not_free");
		transfer(0, make_req(24'hA1_1200, 1'b1, 2'b11, 16'h0100), "ctrl_run");
		zbyte(24'hA0_0010, 1'b0, 8'h00, "zbus_read");

		for (int i = 0; i < 12; i++) begin
			zb = 24'hA0_0000 + 24'($urandom % 24'h2000);
			zbyte(zb, 1'b1, 8'($urandom), "zbus_write");
			zbyte(zb, 1'b0, 8'h00, "zbus_read");
			zbyte(zb + 24'h2000, 1'b0, 8'h00, "zbus_mirror");
			zbyte(zb + 24'h4000, 1'b0, 8'h00, "zbus_empty");
		end

		transfer(0, make_req(24'hB0_0000, 1'b0, 2'b11, 16'h0), "unmapped");
		transfer(0, make_req(24'hA1_2000, 1'b0, 2'b11, 16'h0), "unmapped");
		transfer(0, make_req(24'hC0_0000, 1'b0, 2'b11, 16'h0), "unmapped");

		fork
			ram_traffic(0, 24'hE0_0000, MIX_XFERS, "mix_m0");
			ram_traffic(1, 24'hE0_1000, MIX_XFERS, "mix_m1");
			ram_traffic(2, 24'hE0_2000, MIX_XFERS, "mix_m2");
		join

		repeat (4) @(posedge MCLK);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== work_ram.sv ====
// ------------------
// Work RAM
// 32K words, separate byte lanes, one synchronous read port
// ------------------

module work_ram (
	input  logic                 MCLK,
	input  logic                 we,
	input  logic [1:0]           be,
	input  logic [14:0]          addr,
	input  mbus_pkg::mbus_word_t d,
	output mbus_pkg::mbus_word_t q
);
	import mbus_pkg::*;
	import map_pkg::*;

	// Upper lane holds the even byte
	logic [7:0] mem_hi [RAM_WORDS];
	logic [7:0] mem_lo [RAM_WORDS];

	always_ff @(posedge MCLK) begin
		if (we && be[1])
			mem_hi[addr] <= d[15:8];
		if (we && be[0])
			mem_lo[addr] <= d[7:0];
		q <= mbus_word_t'({mem_hi[addr], mem_lo[addr]});
	end

endmodule

// ==== zbus_bridge.sv ====
// ------------------
// Z80 bus window
// Byte-wide Z80 RAM behind the bus request and reset gates,
// answers two cycles after start
// ------------------

module zbus_bridge (
	input  logic                MCLK,
	input  logic                reset,
	input  logic                start,
	input  mbus_pkg::mbus_req_t zcmd,
	input  logic                busreq,
	input  logic                run,
	output logic                zdone,
	output logic [7:0]          zq
);
	import mbus_pkg::*;
	import map_pkg::*;

	logic [7:0]  zram [2 * ZRAM_WORDS];
	mbus_req_t   cmd_q;
	logic        free_q;
	logic [1:0]  zcnt;
	logic [14:0] zbyte;
	logic        zram_hit;
	logic [7:0]  wbyte;
	logic [7:0]  rbyte;

	// Even byte on the upper lane, upper lane wins when both are set
	assign zbyte    = {cmd_q.addr[14:1], ~cmd_q.be[1]};
	// 4000-7FFF has nothing behind it
	assign zram_hit = free_q && !zbyte[14];
	assign wbyte    = cmd_q.be[1] ? cmd_q.wdata[15:8] : cmd_q.wdata[7:0];

	always_ff @(posedge MCLK) begin
		if (start) begin
			cmd_q  <= zcmd;
			free_q <= busreq & run;
		end
	end

	// ------------------
	// Access counter
	// ------------------
	always_ff @(posedge MCLK) begin
		if (reset)
			zcnt <= 2'd0;
		else if (start)
			zcnt <= 2'd1;
		else if (zcnt == 2'd1)
			zcnt <= 2'd2;
		else
			zcnt <= 2'd0;
	end

	// Bit 13 dropped, 2000-3FFF mirrors the RAM
	always_ff @(posedge MCLK) begin
		if (zcnt == 2'd1) begin
			if (zram_hit && cmd_q.we)
				zram[zbyte[12:0]] <= wbyte;
			rbyte <= zram[zbyte[12:0]];
		end
	end

	assign zdone = (zcnt == 2'd2);
	assign zq    = zram_hit ? rbyte : 8'hFF;

endmodule
